/* include/rvj1_config.svh */
// Width settings for the RV32I slice, included by the package and the testbench
`ifndef RVJ1_CONFIG_SVH
`define RVJ1_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data and instruction word width
`define RVJ1_XLEN 32

// Register index width, enough for x0 to x31
`define RVJ1_RALEN 5

//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

`define RVJ1_NREGS 32 // Including the hardwired x0

`endif

/* hdl/rvj1_defines.sv */
// Shared types and encodings for the RV32I slice, imported by every RTL file
`include "rvj1_config.svh"

package rvj1_defines;

  //////////////////////////////////////////////////
  // Width types
  //////////////////////////////////////////////////

  typedef logic [`RVJ1_XLEN-1:0]  xlen_t;  // Data words, instructions, immediates
  typedef logic [`RVJ1_RALEN-1:0] raddr_t; // Register index

  //////////////////////////////////////////////////
  // Major opcodes, instruction bits 6:0
  //////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD    = 7'b000_0011,
    OPCODE_MISCMEM = 7'b000_1111,
    OPCODE_OPIMM   = 7'b001_0011, // Decoded
    OPCODE_AUIPC   = 7'b001_0111,
    OPCODE_STORE   = 7'b010_0011,
    OPCODE_OP      = 7'b011_0011,
    OPCODE_LUI     = 7'b011_0111, // Decoded
    OPCODE_BRANCH  = 7'b110_0011,
    OPCODE_JALR    = 7'b110_0111,
    OPCODE_JAL     = 7'b110_1111,
    OPCODE_SYSTEM  = 7'b111_0011
  } opcode_e;

  // funct3 within OP-IMM
  typedef enum logic [2:0] {
    F3_ADDI      = 3'b000,
    F3_SLLI      = 3'b001,
    F3_SLTI      = 3'b010,
    F3_SLTIU     = 3'b011,
    F3_XORI      = 3'b100,
    F3_SRLI_SRAI = 3'b101, // Bit 30 splits these two
    F3_ORI       = 3'b110,
    F3_ANDI      = 3'b111
  } f3_imm_e;

  //////////////////////////////////////////////////
  // ALU operations, decoder to execute stage
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'd0, // Also LUI and bubbles
    ALU_OP_SLT  = 4'd1,
    ALU_OP_SLTU = 4'd2,
    ALU_OP_XOR  = 4'd3,
    ALU_OP_OR   = 4'd4,
    ALU_OP_AND  = 4'd5,
    ALU_OP_SLL  = 4'd6,
    ALU_OP_SRL  = 4'd7,
    ALU_OP_SRA  = 4'd8
  } alu_op_e;

endpackage

/* hdl/rvj1_dec_exe_if.sv */
// Registered decode bundle from decoder to execute stage, one entry per cycle
`timescale 1ns/1ps

interface rvj1_dec_exe_if import rvj1_defines::*; ();

  raddr_t  rs1_addr; // Source register for operand A
  alu_op_e alu_sel;  // ALU operation
  logic    use_imm;  // Operand B from immediate
  logic    write_rf; // Bundle valid, one write per instruction
  raddr_t  rd_addr;  // Destination register
  xlen_t   imm;      // Extended immediate or shamt

  // Decoder side drives everything
  modport dec (
    output rs1_addr, alu_sel, use_imm, write_rf, rd_addr, imm
  );

  // Execute side only reads
  modport exe (
    input rs1_addr, alu_sel, use_imm, write_rf, rd_addr, imm
  );

endinterface

/* hdl/rvj1_dec.sv */
// RV32I decoder for OP-IMM and LUI, registers one control bundle per accepted word
`timescale 1ns/1ps

module rvj1_dec import rvj1_defines::*; (
  input  logic        clk_i,
  input  logic        rstn_i,
  input  xlen_t       ifu_instr_i, // Word from fetch
  input  logic        ifu_valid_i,
  input  logic        stall_i,     // Back-pressure from downstream
  output logic        ifu_ready_o,
  rvj1_dec_exe_if.dec dec
);

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////

  opcode_e    opcode;
  raddr_t     rd;
  f3_imm_e    funct3;
  raddr_t     rs1;
  logic [6:0] funct7;
  xlen_t      imm_i_type;
  xlen_t      imm_u_type;
  xlen_t      imm_shamt;  // Shift amount from bits 24:20
  logic       accept;

  // Next bundle, before the register stage
  raddr_t  rs1_d;
  alu_op_e alu_d;
  logic    use_imm_d;
  logic    write_d;
  raddr_t  rd_d;
  xlen_t   imm_d;

  assign opcode = opcode_e'(ifu_instr_i[6:0]);
  assign rd     = ifu_instr_i[11:7];
  assign funct3 = f3_imm_e'(ifu_instr_i[14:12]);
  assign rs1    = ifu_instr_i[19:15];
  assign funct7 = ifu_instr_i[31:25];

  assign imm_i_type = {{20{ifu_instr_i[31]}}, ifu_instr_i[31:20]}; // Sign extended
  assign imm_u_type = {ifu_instr_i[31:12], 12'b0};
  assign imm_shamt  = {27'b0, ifu_instr_i[24:20]};

  // Ready follows stall directly
  assign ifu_ready_o = ~stall_i;
  assign accept      = ifu_valid_i & ifu_ready_o;

  //////////////////////////////////////////////////
  // Combinational decode
  //////////////////////////////////////////////////

  always_comb begin
    // Bubble by default
    rs1_d     = '0;
    alu_d     = ALU_OP_ADD;
    use_imm_d = 1'b0;
    write_d   = 1'b0;
    rd_d      = '0;
    imm_d     = '0;
    case (opcode)
      OPCODE_OPIMM: begin
        rs1_d     = rs1;
        use_imm_d = 1'b1;
        write_d   = 1'b1;
        rd_d      = rd;
        imm_d     = imm_i_type;
        case (funct3)
          F3_ADDI:  alu_d = ALU_OP_ADD;
          F3_SLTI:  alu_d = ALU_OP_SLT;
          F3_SLTIU: alu_d = ALU_OP_SLTU;
          F3_XORI:  alu_d = ALU_OP_XOR;
          F3_ORI:   alu_d = ALU_OP_OR;
          F3_ANDI:  alu_d = ALU_OP_AND;
          F3_SLLI: begin
            alu_d = ALU_OP_SLL;
            imm_d = imm_shamt;
          end
          F3_SRLI_SRAI: begin
            alu_d = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL; // Bit 30 selects arithmetic
            imm_d = imm_shamt;
          end
          default: alu_d = ALU_OP_ADD;
        endcase
      end
      OPCODE_LUI: begin
        rs1_d     = '0;         // x0 + imm
        alu_d     = ALU_OP_ADD;
        use_imm_d = 1'b1;
        write_d   = 1'b1;
        rd_d      = rd;
        imm_d     = imm_u_type;
      end
      default: ; // Unsupported, stays a bubble
    endcase
  end

  //////////////////////////////////////////////////
  // Bundle register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec.rs1_addr <= '0;
      dec.alu_sel  <= ALU_OP_ADD;
      dec.use_imm  <= 1'b0;
      dec.write_rf <= 1'b0;
      dec.rd_addr  <= '0;
      dec.imm      <= '0;
    end else if (accept) begin
      dec.rs1_addr <= rs1_d;
      dec.alu_sel  <= alu_d;
      dec.use_imm  <= use_imm_d;
      dec.write_rf <= write_d;
      dec.rd_addr  <= rd_d;
      dec.imm      <= imm_d;
    end else begin
      // No word this cycle, issue a bubble
      dec.rs1_addr <= '0;
      dec.alu_sel  <= ALU_OP_ADD;
      dec.use_imm  <= 1'b0;
      dec.write_rf <= 1'b0;
      dec.rd_addr  <= '0;
      dec.imm      <= '0;
    end
  end

endmodule

/* hdl/rvj1_rf.sv */
// Integer register file, one combinational read and one synchronous write, x0 reads zero
`timescale 1ns/1ps
`include "rvj1_config.svh"

module rvj1_rf import rvj1_defines::*; (
  input  logic   clk_i,
  input  raddr_t raddr_i,
  output xlen_t  rdata_o,
  input  logic   we_i,
  input  raddr_t waddr_i,
  input  xlen_t  wdata_i
);

  //////////////////////////////////////////////////
  // Storage for x1 to x31
  //////////////////////////////////////////////////

  xlen_t regs_q [1:`RVJ1_NREGS-1]; // No x0 entry, contents not reset

  // Writes to x0 are dropped
  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  always_comb begin
    if (raddr_i == '0) begin
      rdata_o = '0; // Hardwired zero
    end else begin
      rdata_o = regs_q[raddr_i];
    end
  end

endmodule

/* hdl/rvj1_exe.sv */
// Execute stage: reads rs1, runs the ALU on the decode bundle and writes the result back
`timescale 1ns/1ps

module rvj1_exe import rvj1_defines::*; (
  input  logic        clk_i,
  input  logic        rstn_i,
  rvj1_dec_exe_if.exe dec,
  output raddr_t      rf_raddr_o,
  input  xlen_t       rf_rdata_i,
  output logic        rf_we_o,
  output raddr_t      rf_waddr_o,
  output xlen_t       rf_wdata_o,
  output logic        wb_valid_o,
  output raddr_t      wb_addr_o,
  output xlen_t       wb_data_o
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;

  //////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////

  assign rf_raddr_o = dec.rs1_addr; // Read same cycle as the bundle
  assign op_a       = rf_rdata_i;
  assign op_b       = dec.use_imm ? dec.imm : '0; // Bubbles carry zero
  assign shamt      = op_b[4:0];

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (dec.alu_sel)
      ALU_OP_ADD:  alu_res = op_a + op_b;
      ALU_OP_SLT:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_OP_SLTU: alu_res = xlen_t'(op_a < op_b);
      ALU_OP_XOR:  alu_res = op_a ^ op_b;
      ALU_OP_OR:   alu_res = op_a | op_b;
      ALU_OP_AND:  alu_res = op_a & op_b;
      ALU_OP_SLL:  alu_res = op_a << shamt;
      ALU_OP_SRL:  alu_res = op_a >> shamt;
      ALU_OP_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt); // Sign fill
      default:     alu_res = '0;
    endcase
  end

  // Write goes straight to the register file
  assign rf_we_o    = dec.write_rf;
  assign rf_waddr_o = dec.rd_addr;
  assign rf_wdata_o = alu_res;

  //////////////////////////////////////////////////
  // Write-back port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= dec.write_rf; // Same edge as the register write
    end
  end

  // Payload held between writes
  always_ff @(posedge clk_i) begin
    if (dec.write_rf) begin
      wb_addr_o <= dec.rd_addr;
      wb_data_o <= alu_res;
    end
  end

endmodule

/* hdl/rvj1_top.sv */
// Top level of the RV32I slice, connects decoder, register file and execute stage
`timescale 1ns/1ps

module rvj1_top import rvj1_defines::*; (
  input  logic   clk_i,
  input  logic   rstn_i,
  input  xlen_t  ifu_instr_i, // Fetch side
  input  logic   ifu_valid_i,
  output logic   ifu_ready_o,
  input  logic   stall_i,
  output logic   wb_valid_o,  // Write-back observation port
  output raddr_t wb_addr_o,
  output xlen_t  wb_data_o
);

  // Execute stage to register file
  raddr_t rf_raddr;
  xlen_t  rf_rdata;
  logic   rf_we;
  raddr_t rf_waddr;
  xlen_t  rf_wdata;

  //////////////////////////////////////////////////
  // Decode stage
  //////////////////////////////////////////////////

  rvj1_dec_exe_if dec_exe_if ();

  rvj1_dec rvj1_dec_inst (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .ifu_instr_i (ifu_instr_i),
    .ifu_valid_i (ifu_valid_i),
    .stall_i     (stall_i),
    .ifu_ready_o (ifu_ready_o),
    .dec         (dec_exe_if)
  );

  //////////////////////////////////////////////////
  // Execute stage and registers
  //////////////////////////////////////////////////

  rvj1_rf rvj1_rf_inst (
    .clk_i   (clk_i),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  rvj1_exe rvj1_exe_inst (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .dec        (dec_exe_if),
    .rf_raddr_o (rf_raddr),
    .rf_rdata_i (rf_rdata),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .wb_valid_o (wb_valid_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

/* verif/rvj1_assertions.sv */
// Handshake and write-back timing assertions, bound to the slice top level
`timescale 1ns/1ps

module rvj1_assertions (
  input logic clk_i,
  input logic rstn_i,
  input logic ifu_valid_i,
  input logic ifu_ready_o,
  input logic stall_i,
  input logic wb_valid_o
);

  //////////////////////////////////////////////////
  // Fetch handshake
  //////////////////////////////////////////////////

  // Ready is the plain inverse of back-pressure
  a_ready_follows_stall: assert property (@(posedge clk_i) ifu_ready_o == !stall_i)
    else $error("ifu_ready_o does not follow stall_i");

  //////////////////////////////////////////////////
  // Write-back timing
  //////////////////////////////////////////////////

  a_wb_quiet_after_reset: assert property (@(posedge clk_i) $rose(rstn_i) |-> !wb_valid_o)
    else $error("wb_valid_o high right after reset");

  // Two edges from acceptance to a visible write-back
  a_wb_needs_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_valid_o |-> $past(ifu_valid_i && ifu_ready_o, 2))
    else $error("wb_valid_o without a word accepted two edges earlier");

endmodule

bind rvj1_top rvj1_assertions rvj1_assertions_inst (.*);

/* verif/rvj1_tb.sv */
// Testbench for the RV32I slice, random OP-IMM and LUI words checked against a register model
`timescale 1ns/1ps
`include "rvj1_config.svh"

module rvj1_tb import rvj1_defines::*; ();

  localparam int N_FILL  = `RVJ1_NREGS - 1;
  localparam int N_ALU   = 200;
  localparam int N_SHIFT = 100; // Up to two words each
  localparam int N_LUI   = 60;
  localparam int N_STALL = 120; // Up to about six cycles each with gaps
  localparam int N_MIX   = 80;
  localparam int WORST   = N_FILL + N_ALU + 2 * N_SHIFT + N_LUI + 6 * N_STALL + N_MIX;
  localparam int MAX_CYCLES = 2 * WORST + 400; // Roughly 3000

  logic   clk_i;
  logic   rstn_i;
  xlen_t  ifu_instr_i;
  logic   ifu_valid_i;
  logic   ifu_ready_o;
  logic   stall_i;
  logic   wb_valid_o;
  raddr_t wb_addr_o;
  xlen_t  wb_data_o;

  xlen_t       model_regs [0:`RVJ1_NREGS-1]; // Architectural view
  logic [36:0] exp_q [$];                    // {rd, data} in acceptance order
  logic [36:0] mon_exp;
  int          pass_cnt, fail_cnt, exp_cnt, wb_cnt, cycle_cnt;
  int          fail_base, exp_base, wb_base;
  int          seed_ret;
  raddr_t      last_rd;
  xlen_t       word, r;

  rvj1_top rvj1_top_inst (.*);

  always #50 clk_i = ~clk_i; // 100 ns period

  //////////////////////////////////////////////////
  // Word builders and reference model
  //////////////////////////////////////////////////

  function automatic xlen_t make_opimm(f3_imm_e f3, raddr_t rd, raddr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, OPCODE_OPIMM};
  endfunction

  function automatic xlen_t rand_alu_word(raddr_t hot);
    xlen_t   rv;
    f3_imm_e f3;
    raddr_t  rs1;
    rv = $urandom;
    case ($urandom_range(5, 0))
      0: f3 = F3_ADDI;
      1: f3 = F3_SLTI;
      2: f3 = F3_SLTIU;
      3: f3 = F3_XORI;
      4: f3 = F3_ORI;
      default: f3 = F3_ANDI;
    endcase
    rs1 = ($urandom_range(1, 0) == 1) ? hot : rv[19:15]; // Half depend on the last rd
    return make_opimm(f3, rv[11:7], rs1, rv[31:20]);
  endfunction

  task automatic model_issue(input xlen_t instr);
    raddr_t     rd;
    xlen_t      a;
    xlen_t      imm;
    logic [4:0] sh;
    xlen_t      res;
    logic       wr;
    rd  = instr[11:7];
    a   = model_regs[instr[19:15]];
    imm = {{20{instr[31]}}, instr[31:20]};
    sh  = instr[24:20];
    wr  = 1'b1;
    res = '0;
    if (instr[6:0] == OPCODE_OPIMM) begin
      case (f3_imm_e'(instr[14:12]))
        F3_ADDI:  res = a + imm;
        F3_SLTI:  res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        F3_SLTIU: res = (a < imm) ? 32'd1 : 32'd0;
        F3_XORI:  res = a ^ imm;
        F3_ORI:   res = a | imm;
        F3_ANDI:  res = a & imm;
        F3_SLLI:  res = a << sh;
        default:  res = instr[30] ? xlen_t'($signed(a) >>> sh) : (a >> sh); // SRAI or SRLI
      endcase
    end else if (instr[6:0] == OPCODE_LUI) begin
      res = {instr[31:12], 12'b0};
    end else begin
      wr = 1'b0; // Bubble
    end
    if (wr) begin
      if (rd != '0) model_regs[rd] = res; // x0 stays zero
      exp_q.push_back({rd, res});
      exp_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers, 1 ns after the rising edge
  //////////////////////////////////////////////////

  task automatic send_word(input xlen_t instr, input int stall_pct);
    logic done;
    done = 1'b0;
    while (!done) begin
      ifu_instr_i = instr; // Held until taken
      ifu_valid_i = 1'b1;
      stall_i     = ($urandom_range(99, 0) < stall_pct);
      @(negedge clk_i);
      if (ifu_valid_i && !stall_i) begin // Taken whenever not stalled
        model_issue(instr);
        done = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    last_rd = instr[11:7];
  endtask

  task automatic idle_cycle(input logic stall);
    ifu_instr_i = $urandom; // Ignored without valid
    ifu_valid_i = 1'b0;
    stall_i     = stall;
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input int num, input string name);
    while (exp_q.size() != 0) idle_cycle(1'b0);
    repeat (3) idle_cycle(1'b0); // Catch stray write-backs
    assert (wb_cnt - wb_base == exp_cnt - exp_base) pass_cnt++;
    else begin
      fail_cnt++;
      $display("ERR %0d ns: %0d write-backs for %0d writing words", $time,
               wb_cnt - wb_base, exp_cnt - exp_base);
    end
    $display("Test %0d %s: %0d write-backs, %0d errors", num, name,
             wb_cnt - wb_base, fail_cnt - fail_base);
    wb_base   = wb_cnt;
    exp_base  = exp_cnt;
    fail_base = fail_cnt;
  endtask

  //////////////////////////////////////////////////
  // Write-back monitor and timeout
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rstn_i && wb_valid_o) begin
      wb_cnt++;
      assert (exp_q.size() != 0)
      else begin
        fail_cnt++;
        $display("Write-back to x%0d at %0d ns with no instruction outstanding", wb_addr_o, $time);
      end
      if (exp_q.size() != 0) begin
        mon_exp = exp_q.pop_front();
        assert (wb_addr_o == mon_exp[36:32] && wb_data_o == mon_exp[31:0]) pass_cnt++;
        else begin
          fail_cnt++;
          $display("ERR %0d ns: wb x%0d = %h, expected x%0d = %h", $time,
                   wb_addr_o, wb_data_o, mon_exp[36:32], mon_exp[31:0]);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed_ret = $urandom(38163);
    clk_i = 1'b0;
    rstn_i = 1'b0;
    ifu_instr_i = '0;
    ifu_valid_i = 1'b0;
    stall_i = 1'b0;
    {pass_cnt, fail_cnt, exp_cnt, wb_cnt, cycle_cnt} = '0;
    {fail_base, exp_base, wb_base} = '0;
    last_rd = '0;
    for (int i = 0; i < `RVJ1_NREGS; i++) model_regs[i] = '0;
    repeat (4) @(posedge clk_i); // Reset for 4 cycles
    #1 rstn_i = 1'b1;

    // ADDI from x0 into every register
    for (int i = 1; i <= N_FILL; i++) begin
      r = $urandom;
      send_word(make_opimm(F3_ADDI, raddr_t'(i), '0, r[11:0]), 0);
    end
    finish_test(1, "register fill");

    for (int i = 0; i < N_ALU; i++) send_word(rand_alu_word(last_rd), 0);
    finish_test(2, "random OP-IMM");

    // Negative source via LUI, then the shift reads it right away
    for (int i = 0; i < N_SHIFT; i++) begin
      r = $urandom;
      if (r[0]) send_word({1'b1, r[30:12], r[19:15], OPCODE_LUI}, 0);
      case ($urandom_range(2, 0))
        0: word = make_opimm(F3_SLLI, r[11:7], r[19:15], {7'b0, r[24:20]});
        1: word = make_opimm(F3_SRLI_SRAI, r[11:7], r[19:15], {7'b0, r[24:20]});
        default: word = make_opimm(F3_SRLI_SRAI, r[11:7], r[19:15], {7'b0100000, r[24:20]});
      endcase
      send_word(word, 0);
    end
    finish_test(3, "shifts");

    for (int i = 0; i < N_LUI; i++) begin
      r = $urandom;
      send_word({r[31:12], r[11:7], OPCODE_LUI}, 0);
    end
    finish_test(4, "LUI");

    // Valid gaps and back-pressure
    for (int i = 0; i < N_STALL; i++) begin
      repeat ($urandom_range(2, 0)) idle_cycle($urandom_range(1, 0) == 1);
      send_word(rand_alu_word(last_rd), 30);
    end
    finish_test(5, "stall and gaps");

    for (int i = 0; i < N_MIX; i++) begin
      r = $urandom;
      if ($urandom_range(2, 0) == 0) begin
        // Flipping bit 2 turns OP-IMM into AUIPC and LUI into OP
        if (r[6:0] == OPCODE_OPIMM || r[6:0] == OPCODE_LUI) r[2] = ~r[2];
        send_word(r, 0);
      end else begin
        send_word(rand_alu_word(last_rd), 0);
      end
    end
    finish_test(6, "unsupported opcodes");

    $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
hdl/rvj1_defines.sv
hdl/rvj1_dec_exe_if.sv
hdl/rvj1_dec.sv
hdl/rvj1_rf.sv
hdl/rvj1_exe.sv
hdl/rvj1_top.sv
verif/rvj1_assertions.sv
verif/rvj1_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass message
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rvj1_tb -o rvj1_sim \
  && ./obj_dir/rvj1_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
